//--- hw/arm_isa_pkg.sv
package arm_isa_pkg;

    // raw instruction word
    typedef logic [31:0] instr_t;

    // op field, other encodings decode as a no-op
    typedef enum logic [1:0] {
        op_data_proc = 2'b00,
        op_memory    = 2'b01
    } op_t;

    // data processing commands
    typedef enum logic [3:0] {
        cmd_and = 4'b0000,
        cmd_sub = 4'b0010,
        cmd_add = 4'b0100,
        cmd_orr = 4'b1100,
        cmd_mov = 4'b1101
    } cmd_t;

    ////////////////////////////////////////
    // field positions

    localparam int unsigned op_lsb  = 26;
    localparam int unsigned i_bit   = 25;
    localparam int unsigned cmd_lsb = 21;
    localparam int unsigned u_bit   = 23;
    localparam int unsigned l_bit   = 20;
    localparam int unsigned rn_lsb  = 16;
    localparam int unsigned rd_lsb  = 12;
    localparam int unsigned rm_lsb  = 0;

    // immediate fields, both start at bit 0
    localparam int unsigned imm8_lsb    = 0;
    localparam int unsigned imm8_width  = 8;
    localparam int unsigned imm12_lsb   = 0;
    localparam int unsigned imm12_width = 12;

    // op = 10 falls outside the kept subset
    localparam instr_t nop_instr = 32'h0800_0000;

endpackage

//--- hw/core_types_pkg.sv
package core_types_pkg;

    // datapath word and register number
    typedef logic [31:0] word_t;
    typedef logic [3:0]  reg_addr_t;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_orr,
        alu_pass_b
    } alu_op_t;

    // operand source in execute
    typedef enum logic [1:0] {
        fwd_none,
        fwd_wb,
        fwd_mem
    } fwd_sel_t;

    // r0 to r14, r15 is not kept
    localparam int unsigned num_gp_regs = 15;

endpackage

//--- hw/fetch_stage.sv
module fetch_stage #(
    parameter core_types_pkg::word_t reset_pc = '0
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  stall,
    input  arm_isa_pkg::instr_t   instr,
    output core_types_pkg::word_t pc,
    output arm_isa_pkg::instr_t   instr_f
);

    // pc steps one word per cycle, held while decode is stalled
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc <= reset_pc;
        end else if (!stall) begin
            pc <= pc + 32'd4;
        end
    end

    // memory answers in the same cycle
    assign instr_f = instr;

endmodule

//--- hw/reg_file.sv
module reg_file (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      we,
    input  core_types_pkg::reg_addr_t a1,
    input  core_types_pkg::reg_addr_t a2,
    input  core_types_pkg::reg_addr_t a3,
    input  core_types_pkg::word_t     wd,
    output core_types_pkg::word_t     rd1,
    output core_types_pkg::word_t     rd2
);
    import core_types_pkg::*;

    word_t regs [num_gp_regs];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < num_gp_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (we && a3 < num_gp_regs) begin
            regs[a3] <= wd;
        end
    end

    // r15 reads as zero, same cycle write passes straight through
    function automatic word_t read_port(reg_addr_t a);
        if (a >= num_gp_regs) begin
            return '0;
        end
        if (we && a == a3) begin
            return wd;
        end
        return regs[a];
    endfunction

    always_comb begin
        rd1 = read_port(a1);
        rd2 = read_port(a2);
    end

endmodule

//--- hw/decode_stage.sv
module decode_stage (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      stall,
    input  arm_isa_pkg::instr_t       instr_f,
    input  logic                      reg_write_w,
    input  core_types_pkg::reg_addr_t wa3_w,
    input  core_types_pkg::word_t     result_w,
    output logic                      reg_write_d,
    output logic                      mem_to_reg_d,
    output logic                      mem_write_d,
    output logic                      alu_src_d,
    output core_types_pkg::alu_op_t   alu_op_d,
    output core_types_pkg::word_t     rd1_d,
    output core_types_pkg::word_t     rd2_d,
    output core_types_pkg::word_t     ext_imm_d,
    output core_types_pkg::reg_addr_t ra1_d,
    output core_types_pkg::reg_addr_t ra2_d,
    output core_types_pkg::reg_addr_t wa3_d
);
    import arm_isa_pkg::*;
    import core_types_pkg::*;

    instr_t    instr_d;
    op_t       op;
    cmd_t      cmd;
    logic      is_store;
    reg_addr_t rn;
    reg_addr_t rd;
    reg_addr_t rm;

    ////////////////////////////////////////
    // decode register

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            instr_d <= nop_instr;
        end else if (!stall) begin
            instr_d <= instr_f;
        end
    end

    ////////////////////////////////////////
    // fields

    assign op  = op_t'(instr_d[op_lsb +: 2]);
    assign cmd = cmd_t'(instr_d[cmd_lsb +: 4]);
    assign rn  = instr_d[rn_lsb +: 4];
    assign rd  = instr_d[rd_lsb +: 4];
    assign rm  = instr_d[rm_lsb +: 4];

    // store data comes from rd
    assign is_store = (op == op_memory) && !instr_d[l_bit];

    assign ra1_d = rn;
    assign ra2_d = is_store ? rd : rm;
    assign wa3_d = rd;

    // zero extended, imm12 for memory and imm8 otherwise
    assign ext_imm_d = (op == op_memory) ? word_t'(instr_d[imm12_lsb +: imm12_width])
                                         : word_t'(instr_d[imm8_lsb +: imm8_width]);

    ////////////////////////////////////////
    // controls

    always_comb begin
        reg_write_d  = 1'b0;
        mem_to_reg_d = 1'b0;
        mem_write_d  = 1'b0;
        alu_src_d    = 1'b0;
        alu_op_d     = alu_add;
        case (op)
            op_data_proc: begin
                alu_src_d   = instr_d[i_bit];
                reg_write_d = 1'b1;
                case (cmd)
                    cmd_and: alu_op_d = alu_and;
                    cmd_sub: alu_op_d = alu_sub;
                    cmd_add: alu_op_d = alu_add;
                    cmd_orr: alu_op_d = alu_orr;
                    cmd_mov: alu_op_d = alu_pass_b;
                    // unsupported command, no write
                    default: reg_write_d = 1'b0;
                endcase
            end
            op_memory: begin
                // base plus or minus imm12
                alu_src_d    = 1'b1;
                alu_op_d     = instr_d[u_bit] ? alu_add : alu_sub;
                reg_write_d  = instr_d[l_bit];
                mem_to_reg_d = instr_d[l_bit];
                mem_write_d  = is_store;
            end
            default: begin
            end
        endcase
    end

    reg_file u_reg_file (
        .clk(clk),
        .reset(reset),
        .we(reg_write_w),
        .a1(ra1_d),
        .a2(ra2_d),
        .a3(wa3_w),
        .wd(result_w),
        .rd1(rd1_d),
        .rd2(rd2_d)
    );

endmodule

//--- hw/execute_stage.sv
module execute_stage (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      flush_e,
    input  logic                      reg_write_d,
    input  logic                      mem_to_reg_d,
    input  logic                      mem_write_d,
    input  logic                      alu_src_d,
    input  core_types_pkg::alu_op_t   alu_op_d,
    input  core_types_pkg::word_t     rd1_d,
    input  core_types_pkg::word_t     rd2_d,
    input  core_types_pkg::word_t     ext_imm_d,
    input  core_types_pkg::reg_addr_t ra1_d,
    input  core_types_pkg::reg_addr_t ra2_d,
    input  core_types_pkg::reg_addr_t wa3_d,
    input  core_types_pkg::fwd_sel_t  forward_a,
    input  core_types_pkg::fwd_sel_t  forward_b,
    input  core_types_pkg::word_t     alu_out_m,
    input  core_types_pkg::word_t     result_w,
    output logic                      reg_write_e,
    output logic                      mem_to_reg_e,
    output logic                      mem_write_e,
    output core_types_pkg::word_t     alu_result_e,
    output core_types_pkg::word_t     write_data_e,
    output core_types_pkg::reg_addr_t wa3_e,
    output core_types_pkg::reg_addr_t ra1_e,
    output core_types_pkg::reg_addr_t ra2_e
);
    import core_types_pkg::*;

    logic    alu_src_e;
    alu_op_t alu_op_e;
    word_t   rd1_e;
    word_t   rd2_e;
    word_t   ext_imm_e;
    word_t   src_a;
    word_t   src_b;

    // a flush only needs to kill the write enables
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            reg_write_e  <= 1'b0;
            mem_to_reg_e <= 1'b0;
            mem_write_e  <= 1'b0;
        end else if (flush_e) begin
            reg_write_e  <= 1'b0;
            mem_to_reg_e <= 1'b0;
            mem_write_e  <= 1'b0;
        end else begin
            reg_write_e  <= reg_write_d;
            mem_to_reg_e <= mem_to_reg_d;
            mem_write_e  <= mem_write_d;
        end
    end

    always_ff @(posedge clk) begin
        alu_src_e <= alu_src_d;
        alu_op_e  <= alu_op_d;
        rd1_e     <= rd1_d;
        rd2_e     <= rd2_d;
        ext_imm_e <= ext_imm_d;
        ra1_e     <= ra1_d;
        ra2_e     <= ra2_d;
        wa3_e     <= wa3_d;
    end

    ////////////////////////////////////////
    // forwarding

    function automatic word_t fwd_mux(fwd_sel_t sel, word_t reg_val);
        case (sel)
            fwd_mem: return alu_out_m;
            fwd_wb:  return result_w;
            default: return reg_val;
        endcase
    endfunction

    always_comb begin
        src_a        = fwd_mux(forward_a, rd1_e);
        write_data_e = fwd_mux(forward_b, rd2_e);
        src_b        = alu_src_e ? ext_imm_e : write_data_e;
    end

    ////////////////////////////////////////
    // alu

    always_comb begin
        case (alu_op_e)
            alu_sub:    alu_result_e = src_a - src_b;
            alu_and:    alu_result_e = src_a & src_b;
            alu_orr:    alu_result_e = src_a | src_b;
            alu_pass_b: alu_result_e = src_b;
            default:    alu_result_e = src_a + src_b;
        endcase
    end

endmodule

//--- hw/mem_wb_stage.sv
module mem_wb_stage (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      reg_write_e,
    input  logic                      mem_to_reg_e,
    input  logic                      mem_write_e,
    input  core_types_pkg::word_t     alu_result_e,
    input  core_types_pkg::word_t     write_data_e,
    input  core_types_pkg::reg_addr_t wa3_e,
    input  core_types_pkg::word_t     read_data,
    output core_types_pkg::word_t     alu_out_m,
    output core_types_pkg::reg_addr_t wa3_m,
    output logic                      reg_write_m,
    output logic                      mem_to_reg_m,
    output logic                      data_we,
    output core_types_pkg::word_t     write_data,
    output core_types_pkg::word_t     result_w,
    output core_types_pkg::reg_addr_t wa3_w,
    output logic                      reg_write_w
);
    import core_types_pkg::*;

    logic  mem_to_reg_w;
    word_t read_data_w;
    word_t alu_out_w;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            reg_write_m  <= 1'b0;
            mem_to_reg_m <= 1'b0;
            data_we      <= 1'b0;
            reg_write_w  <= 1'b0;
            mem_to_reg_w <= 1'b0;
        end else begin
            reg_write_m  <= reg_write_e;
            mem_to_reg_m <= mem_to_reg_e;
            data_we      <= mem_write_e;
            reg_write_w  <= reg_write_m;
            mem_to_reg_w <= mem_to_reg_m;
        end
    end

    // memory rank then writeback rank
    always_ff @(posedge clk) begin
        alu_out_m   <= alu_result_e;
        write_data  <= write_data_e;
        wa3_m       <= wa3_e;
        read_data_w <= read_data;
        alu_out_w   <= alu_out_m;
        wa3_w       <= wa3_m;
    end

    assign result_w = mem_to_reg_w ? read_data_w : alu_out_w;

endmodule

//--- hw/hazard_unit.sv
module hazard_unit (
    input  core_types_pkg::reg_addr_t ra1_e,
    input  core_types_pkg::reg_addr_t ra2_e,
    input  core_types_pkg::reg_addr_t wa3_m,
    input  core_types_pkg::reg_addr_t wa3_w,
    input  core_types_pkg::reg_addr_t ra1_d,
    input  core_types_pkg::reg_addr_t ra2_d,
    input  core_types_pkg::reg_addr_t wa3_e,
    input  logic                      reg_write_m,
    input  logic                      reg_write_w,
    input  logic                      mem_to_reg_e,
    output core_types_pkg::fwd_sel_t  forward_a,
    output core_types_pkg::fwd_sel_t  forward_b,
    output logic                      stall,
    output logic                      flush_e
);
    import core_types_pkg::*;

    // newest producer wins, so memory before writeback
    function automatic fwd_sel_t fwd_select(reg_addr_t src);
        if (reg_write_m && wa3_m == src) begin
            return fwd_mem;
        end
        if (reg_write_w && wa3_w == src) begin
            return fwd_wb;
        end
        return fwd_none;
    endfunction

    always_comb begin
        forward_a = fwd_select(ra1_e);
        forward_b = fwd_select(ra2_e);
    end

    // load data is not ready until writeback
    assign stall   = mem_to_reg_e && (ra1_d == wa3_e || ra2_d == wa3_e);
    assign flush_e = stall;

endmodule

//--- hw/core_top.sv
module core_top #(
    parameter core_types_pkg::word_t reset_pc = '0
) (
    input  logic                  clk,
    input  logic                  reset,
    input  arm_isa_pkg::instr_t   instr,
    input  core_types_pkg::word_t read_data,
    output core_types_pkg::word_t instr_addr,
    output core_types_pkg::word_t data_addr,
    output core_types_pkg::word_t write_data,
    output logic                  data_we
);
    import arm_isa_pkg::*;
    import core_types_pkg::*;

    instr_t    instr_f;

    // decode to execute
    logic      reg_write_d;
    logic      mem_to_reg_d;
    logic      mem_write_d;
    logic      alu_src_d;
    alu_op_t   alu_op_d;
    word_t     rd1_d;
    word_t     rd2_d;
    word_t     ext_imm_d;
    reg_addr_t ra1_d;
    reg_addr_t ra2_d;
    reg_addr_t wa3_d;

    // execute to memory
    logic      reg_write_e;
    logic      mem_to_reg_e;
    logic      mem_write_e;
    word_t     alu_result_e;
    word_t     write_data_e;
    reg_addr_t wa3_e;
    reg_addr_t ra1_e;
    reg_addr_t ra2_e;

    // memory and writeback
    reg_addr_t wa3_m;
    logic      reg_write_m;
    word_t     result_w;
    reg_addr_t wa3_w;
    logic      reg_write_w;

    // hazard controls
    fwd_sel_t  forward_a;
    fwd_sel_t  forward_b;
    logic      stall;
    logic      flush_e;

    fetch_stage #(
        .reset_pc(reset_pc)
    ) u_fetch (
        .clk(clk),
        .reset(reset),
        .stall(stall),
        .instr(instr),
        .pc(instr_addr),
        .instr_f(instr_f)
    );

    decode_stage u_decode (
        .clk(clk),
        .reset(reset),
        .stall(stall),
        .instr_f(instr_f),
        .reg_write_w(reg_write_w),
        .wa3_w(wa3_w),
        .result_w(result_w),
        .reg_write_d(reg_write_d),
        .mem_to_reg_d(mem_to_reg_d),
        .mem_write_d(mem_write_d),
        .alu_src_d(alu_src_d),
        .alu_op_d(alu_op_d),
        .rd1_d(rd1_d),
        .rd2_d(rd2_d),
        .ext_imm_d(ext_imm_d),
        .ra1_d(ra1_d),
        .ra2_d(ra2_d),
        .wa3_d(wa3_d)
    );

    // the memory stage alu output doubles as the data address
    execute_stage u_execute (
        .clk(clk),
        .reset(reset),
        .flush_e(flush_e),
        .reg_write_d(reg_write_d),
        .mem_to_reg_d(mem_to_reg_d),
        .mem_write_d(mem_write_d),
        .alu_src_d(alu_src_d),
        .alu_op_d(alu_op_d),
        .rd1_d(rd1_d),
        .rd2_d(rd2_d),
        .ext_imm_d(ext_imm_d),
        .ra1_d(ra1_d),
        .ra2_d(ra2_d),
        .wa3_d(wa3_d),
        .forward_a(forward_a),
        .forward_b(forward_b),
        .alu_out_m(data_addr),
        .result_w(result_w),
        .reg_write_e(reg_write_e),
        .mem_to_reg_e(mem_to_reg_e),
        .mem_write_e(mem_write_e),
        .alu_result_e(alu_result_e),
        .write_data_e(write_data_e),
        .wa3_e(wa3_e),
        .ra1_e(ra1_e),
        .ra2_e(ra2_e)
    );

    mem_wb_stage u_mem_wb (
        .clk(clk),
        .reset(reset),
        .reg_write_e(reg_write_e),
        .mem_to_reg_e(mem_to_reg_e),
        .mem_write_e(mem_write_e),
        .alu_result_e(alu_result_e),
        .write_data_e(write_data_e),
        .wa3_e(wa3_e),
        .read_data(read_data),
        .alu_out_m(data_addr),
        .wa3_m(wa3_m),
        .reg_write_m(reg_write_m),
        .mem_to_reg_m(),
        .data_we(data_we),
        .write_data(write_data),
        .result_w(result_w),
        .wa3_w(wa3_w),
        .reg_write_w(reg_write_w)
    );

    hazard_unit u_hazard (
        .ra1_e(ra1_e),
        .ra2_e(ra2_e),
        .wa3_m(wa3_m),
        .wa3_w(wa3_w),
        .ra1_d(ra1_d),
        .ra2_d(ra2_d),
        .wa3_e(wa3_e),
        .reg_write_m(reg_write_m),
        .reg_write_w(reg_write_w),
        .mem_to_reg_e(mem_to_reg_e),
        .forward_a(forward_a),
        .forward_b(forward_b),
        .stall(stall),
        .flush_e(flush_e)
    );

endmodule

//--- dv/core_tb.sv
module core_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import arm_isa_pkg::*;
    import core_types_pkg::*;

    localparam word_t       reset_pc     = 32'h0;
    localparam int unsigned reset_cycles = 10;
    localparam int unsigned imem_words   = 128;
    localparam int unsigned dmem_words   = 256;

    logic   clk;
    logic   reset;
    instr_t instr;
    word_t  read_data;
    word_t  instr_addr;
    word_t  data_addr;
    word_t  write_data;
    logic   data_we;

    instr_t      imem [imem_words];
    word_t       dmem [dmem_words];
    word_t       model_mem [dmem_words];
    instr_t      prog [$];
    word_t       store_addr [$];
    word_t       store_data [$];
    word_t       exp_addr [$];
    word_t       exp_data [$];
    int unsigned fetch_holds;
    int unsigned budget_cycles = 0;
    int unsigned cycle_count;

    core_top #(
        .reset_pc(reset_pc)
    ) DUT (
        .clk(clk),
        .reset(reset),
        .instr(instr),
        .read_data(read_data),
        .instr_addr(instr_addr),
        .data_addr(data_addr),
        .write_data(write_data),
        .data_we(data_we)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    ////////////////////////////////////////
    // memories

    // both answer without a clock edge
    assign instr     = (instr_addr < 4 * imem_words) ? imem[instr_addr[8:2]] : nop_instr;
    assign read_data = dmem[data_addr[9:2]];

    always @(posedge clk) begin
        if (data_we) begin
            dmem[data_addr[9:2]] <= write_data;
            store_addr.push_back(data_addr);
            store_data.push_back(write_data);
        end
    end

    // spreads the whole word index over the data word
    function automatic word_t fill_word(int unsigned idx);
        return (idx * 32'h9e37_79b9) ^ 32'h5a5a_0f0f;
    endfunction

    // copies the program and refills the data memory
    task automatic load_memories();
        for (int i = 0; i < imem_words; i++) begin
            imem[i] = (i < prog.size()) ? prog[i] : nop_instr;
        end
        for (int i = 0; i < dmem_words; i++) begin
            dmem[i] = fill_word(i);
        end
    endtask

    ////////////////////////////////////////
    // instruction encoders

    // src2 is imm8 or rm with a zero shift field
    function automatic instr_t dp_instr(cmd_t cmd, logic imm, reg_addr_t rd, reg_addr_t rn,
                                       logic [7:0] src2);
        instr_t w;
        w = '0;
        w[31:28] = 4'he;
        w[op_lsb +: 2] = op_data_proc;
        w[i_bit] = imm;
        w[cmd_lsb +: 4] = cmd;
        w[rn_lsb +: 4] = rn;
        w[rd_lsb +: 4] = rd;
        w[imm8_lsb +: imm8_width] = src2;
        return w;
    endfunction

    function automatic instr_t mem_instr(logic load, logic up, reg_addr_t rd, reg_addr_t rn,
                                        logic [11:0] offset);
        instr_t w;
        w = '0;
        w[31:28] = 4'he;
        w[op_lsb +: 2] = op_memory;
        w[u_bit] = up;
        w[l_bit] = load;
        w[rn_lsb +: 4] = rn;
        w[rd_lsb +: 4] = rd;
        w[imm12_lsb +: imm12_width] = offset;
        return w;
    endfunction

    // looks like an add into rd apart from the op field
    function automatic instr_t other_op(logic [1:0] op, reg_addr_t rd);
        instr_t w;
        w = dp_instr(cmd_add, 1'b1, rd, rd, 8'h7f);
        w[op_lsb +: 2] = op;
        return w;
    endfunction

    ////////////////////////////////////////
    // reference model and checks

    task automatic check_equal(input word_t actual, input word_t expected, input string what);
        if (actual !== expected) begin
            $display("FAIL at %0d ns: %s, got %h, expected %h", $time, what, actual, expected);
            $display("ERRORS FOUND");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    // executes one instruction at a time with r15 fixed at zero
    task automatic predict_stores();
        word_t     regs [16];
        word_t     a;
        word_t     b;
        word_t     addr;
        instr_t    w;
        reg_addr_t rd;
        for (int i = 0; i < 16; i++) begin
            regs[i] = '0;
        end
        for (int i = 0; i < dmem_words; i++) begin
            model_mem[i] = fill_word(i);
        end
        exp_addr.delete();
        exp_data.delete();
        foreach (prog[k]) begin
            w  = prog[k];
            rd = w[rd_lsb +: 4];
            a  = regs[w[rn_lsb +: 4]];
            b  = w[i_bit] ? word_t'(w[imm8_lsb +: imm8_width]) : regs[w[rm_lsb +: 4]];
            if (w[op_lsb +: 2] == op_data_proc && rd != 4'd15) begin
                case (w[cmd_lsb +: 4])
                    cmd_add: regs[rd] = a + b;
                    cmd_sub: regs[rd] = a - b;
                    cmd_and: regs[rd] = a & b;
                    cmd_orr: regs[rd] = a | b;
                    cmd_mov: regs[rd] = b;
                    default: begin
                    end
                endcase
            end else if (w[op_lsb +: 2] == op_memory) begin
                addr = w[u_bit] ? a + word_t'(w[imm12_lsb +: imm12_width])
                                : a - word_t'(w[imm12_lsb +: imm12_width]);
                if (!w[l_bit]) begin
                    exp_addr.push_back(addr);
                    exp_data.push_back(regs[rd]);
                    model_mem[addr[9:2]] = regs[rd];
                end else if (rd != 4'd15) begin
                    regs[rd] = model_mem[addr[9:2]];
                end
            end
        end
    endtask

    // loads the program under reset, runs until drained and compares stores
    task automatic run_program();
        word_t prev;
        word_t last_addr;
        budget_cycles += prog.size() + 50;
        predict_stores();
        last_addr = 4 * prog.size();
        @(posedge clk);
        reset <= 1'b1;
        @(negedge clk);
        load_memories();
        store_addr.delete();
        store_data.delete();
        check_equal(data_we, 1'b0, "data_we during reset");
        repeat (reset_cycles) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_equal(instr_addr, reset_pc, "first fetch address after reset");
        prev = instr_addr;
        fetch_holds = 0;
        while (instr_addr != last_addr) begin
            @(negedge clk);
            if (instr_addr == prev) begin
                fetch_holds++;
            end else begin
                check_equal(instr_addr, prev + 32'd4, "fetch address step");
            end
            prev = instr_addr;
        end
        // last store leaves the memory stage within four edges
        repeat (5) @(posedge clk);
        check_equal(store_addr.size(), exp_addr.size(), "number of stores");
        foreach (exp_addr[i]) begin
            check_equal(store_addr[i], exp_addr[i], $sformatf("store %0d address", i));
            check_equal(store_data[i], exp_data[i], $sformatf("store %0d data", i));
        end
    endtask

    ////////////////////////////////////////
    // directed tests

    task automatic fetch_after_reset();
        prog.delete();
        repeat (12) prog.push_back(nop_instr);
        run_program();
        check_equal(fetch_holds, 0, "fetch holds in the no-op program");
    endtask

    task automatic alu_operations();
        cmd_t      cmds [5];
        reg_addr_t ra;
        reg_addr_t rb;
        cmds = '{cmd_add, cmd_sub, cmd_and, cmd_orr, cmd_mov};
        ra = $urandom_range(6, 1);
        rb = $urandom_range(12, 7);
        prog.delete();
        foreach (cmds[k]) begin
            prog.push_back(dp_instr(cmd_mov, 1'b1, ra, 0, $urandom_range(255)));
            prog.push_back(dp_instr(cmds[k], 1'b1, 13, ra, $urandom_range(255)));
            prog.push_back(mem_instr(1'b0, 1'b1, 13, 0, 12'h200 + 4 * k));
        end
        // full width operands out of the data memory fill
        prog.push_back(mem_instr(1'b1, 1'b1, ra, 0, 4 * $urandom_range(63)));
        prog.push_back(mem_instr(1'b1, 1'b1, rb, 0, 4 * $urandom_range(63)));
        foreach (cmds[k]) begin
            prog.push_back(dp_instr(cmds[k], 1'b0, 14, ra, rb));
            prog.push_back(mem_instr(1'b0, 1'b1, 14, 0, 12'h240 + 4 * k));
        end
        run_program();
    endtask

    task automatic dependent_chains();
        prog.delete();
        // distance one
        prog.push_back(dp_instr(cmd_mov, 1'b1, 1, 0, 8'h3c));
        prog.push_back(dp_instr(cmd_add, 1'b1, 2, 1, 8'h11));
        prog.push_back(mem_instr(1'b0, 1'b1, 2, 0, 12'h100));
        // distance two
        prog.push_back(dp_instr(cmd_mov, 1'b1, 3, 0, 8'h9a));
        prog.push_back(dp_instr(cmd_mov, 1'b1, 9, 0, 8'h01));
        prog.push_back(dp_instr(cmd_sub, 1'b1, 4, 3, 8'h27));
        prog.push_back(dp_instr(cmd_mov, 1'b1, 10, 0, 8'h02));
        prog.push_back(mem_instr(1'b0, 1'b1, 4, 0, 12'h104));
        // distance three through the register file
        prog.push_back(dp_instr(cmd_mov, 1'b1, 5, 0, 8'hf0));
        prog.push_back(dp_instr(cmd_mov, 1'b1, 9, 0, 8'h03));
        prog.push_back(dp_instr(cmd_mov, 1'b1, 10, 0, 8'h04));
        prog.push_back(dp_instr(cmd_orr, 1'b0, 6, 5, 2));
        prog.push_back(dp_instr(cmd_mov, 1'b1, 9, 0, 8'h05));
        prog.push_back(mem_instr(1'b0, 1'b1, 6, 0, 12'h108));
        // r7 sits in memory and writeback at once
        prog.push_back(dp_instr(cmd_mov, 1'b1, 7, 0, 8'h01));
        prog.push_back(dp_instr(cmd_add, 1'b1, 7, 7, 8'h02));
        prog.push_back(dp_instr(cmd_add, 1'b1, 7, 7, 8'h04));
        prog.push_back(dp_instr(cmd_and, 1'b0, 8, 7, 4));
        prog.push_back(mem_instr(1'b0, 1'b1, 8, 0, 12'h10c));
        prog.push_back(mem_instr(1'b0, 1'b1, 7, 0, 12'h110));
        run_program();
    endtask

    task automatic load_use_stall();
        prog.delete();
        prog.push_back(dp_instr(cmd_mov, 1'b1, 1, 0, 8'h07));
        prog.push_back(mem_instr(1'b1, 1'b1, 3, 0, 12'h010));
        prog.push_back(dp_instr(cmd_add, 1'b0, 4, 3, 1));
        prog.push_back(mem_instr(1'b0, 1'b1, 4, 0, 12'h300));
        // loaded register as store data
        prog.push_back(mem_instr(1'b1, 1'b1, 5, 0, 12'h020));
        prog.push_back(mem_instr(1'b0, 1'b1, 5, 0, 12'h304));
        prog.push_back(mem_instr(1'b1, 1'b1, 6, 0, 12'h024));
        prog.push_back(dp_instr(cmd_sub, 1'b1, 7, 6, 8'h01));
        prog.push_back(mem_instr(1'b0, 1'b1, 7, 0, 12'h308));
        run_program();
        check_equal(fetch_holds, 3, "fetch holds for three load-use pairs");
    endtask

    task automatic subtract_offset_and_no_op();
        prog.delete();
        prog.push_back(dp_instr(cmd_mov, 1'b1, 1, 0, 8'hc0));
        prog.push_back(mem_instr(1'b1, 1'b0, 2, 1, 12'h040));
        prog.push_back(dp_instr(cmd_mov, 1'b1, 3, 0, 8'h55));
        prog.push_back(mem_instr(1'b0, 1'b0, 3, 1, 12'h020));
        prog.push_back(mem_instr(1'b1, 1'b0, 4, 1, 12'h020));
        prog.push_back(mem_instr(1'b0, 1'b1, 2, 0, 12'h380));
        prog.push_back(mem_instr(1'b0, 1'b1, 4, 0, 12'h384));
        // op classes 10 and 11 aimed at r3
        prog.push_back(other_op(2'b10, 3));
        prog.push_back(other_op(2'b11, 3));
        prog.push_back(mem_instr(1'b0, 1'b1, 3, 0, 12'h388));
        // base below the offset wraps around
        prog.push_back(mem_instr(1'b0, 1'b0, 3, 1, 12'h100));
        run_program();
    endtask

    ////////////////////////////////////////
    // watchdog and main sequence

    initial begin
        cycle_count = 0;
        while (cycle_count <= budget_cycles) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: the run did not finish within %0d clock cycles", budget_cycles);
        $display("ERRORS FOUND");
        $fatal(1, "watchdog expired");
    end

    initial begin
        reset = 1'b1;
        void'($urandom(76416));
        load_memories();
        fetch_after_reset();
        alu_operations();
        dependent_chains();
        load_use_stall();
        subtract_offset_and_no_op();
        $display("NO ERRORS");
        $finish;
    end

endmodule

//--- filelist.f
hw/arm_isa_pkg.sv
hw/core_types_pkg.sv
hw/fetch_stage.sv
hw/reg_file.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/mem_wb_stage.sv
hw/hazard_unit.sv
hw/core_top.sv
dv/core_tb.sv
